// File: common/dpf_params.svh
// Lane count, lane depth and symbol width for the striped symbol FIFO
// DPF_LANES must be 2 or more for the per-lane full rule to hold
// Each lane keeps one slot free, so a lane stores 2**DPF_ADR_WIDTH - 1 symbols

`ifndef DPF_PARAMS_SVH
`define DPF_PARAMS_SVH

// Number of lane FIFOs in the bank
`define DPF_LANES 4

// Lane address width, 8 words per lane
`define DPF_ADR_WIDTH 3

// Symbol width
`define DPF_SYM_WIDTH 10

`endif

// File: common/dpf_pkg.sv
// Types shared by the distributor, the lanes and the collector
// Widths come from dpf_params.svh

`include "dpf_params.svh"

package dpf_pkg;

	// One symbol
	typedef logic [`DPF_SYM_WIDTH-1:0] sym_t;

	// Lane pointers and counts
	typedef logic [`DPF_ADR_WIDTH-1:0] lane_adr_t;
	typedef logic [`DPF_ADR_WIDTH:0] lane_wrds_t;

	// Lane index and total count over all lanes
	typedef logic [$clog2(`DPF_LANES)-1:0] lane_sel_t;
	typedef logic [`DPF_ADR_WIDTH+$clog2(`DPF_LANES):0] bank_wrds_t;

	// Command to one lane
	typedef enum logic [1:0]
	{
		LANE_NOP,
		LANE_WRITE,
		LANE_CLEAR
	} lane_op_e;

	typedef struct packed
	{
		lane_op_e op;
		sym_t dat;
	} lane_wr_t;

	// Lane status
	typedef struct packed
	{
		lane_wrds_t wrds; // Used words, registered
		logic ep;
		logic fl;
	} lane_sta_t;

	// Read data with its enable
	typedef struct packed
	{
		logic de;
		sym_t dat;
	} rd_rsp_t;

endpackage

// File: logic/lane_distributor.sv
// Spreads incoming symbols over the lanes in round-robin order
// A write to a full lane is dropped and the selector stays put
// Clear goes to every lane and returns the selector to lane 0

`timescale 1ns/100ps

`include "dpf_params.svh"

module lane_distributor
(
	input logic RST_IN, // Clock
	input logic CLK_IN, // Reset
	input logic clr,
	input logic wr,
	input dpf_pkg::sym_t wr_dat,
	input dpf_pkg::lane_sta_t [`DPF_LANES-1:0] lane_sta,
	output dpf_pkg::lane_wr_t [`DPF_LANES-1:0] lane_wr,
	output logic fl
);
	import dpf_pkg::*;

	lane_sel_t wsel; // Lane that takes the next symbol
	logic wr_ok;

	// Bank is full when the next lane is
	assign fl = lane_sta[wsel].fl;
	assign wr_ok = wr && !clr && !fl;

	// Write lane selector
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			wsel <= '0;
		else
		begin
			if (clr)
				wsel <= '0;
			else if (wr_ok)
			begin
				if (wsel == lane_sel_t'(`DPF_LANES - 1))
					wsel <= '0;
				else
					wsel <= wsel + 1'b1;
			end
		end
	end

	// Lane commands
	always_comb
	begin
		for (int i = 0; i < `DPF_LANES; i++)
		begin
			lane_wr[i].dat = wr_dat; // Same data to every lane
			if (clr)
				lane_wr[i].op = LANE_CLEAR;
			else if (wr_ok && (wsel == lane_sel_t'(i)))
				lane_wr[i].op = LANE_WRITE;
			else
				lane_wr[i].op = LANE_NOP;
		end
	end

endmodule

// File: lane_fifo/lane_fifo.sv
// One lane of the bank, 2**DPF_ADR_WIDTH words with one slot kept free
// Strobes are not checked against full or empty in here
// Clear wins over write and read

`timescale 1ns/100ps

`include "dpf_params.svh"

module lane_fifo
(
	input logic RST_IN, // Clock
	input logic CLK_IN, // Reset, async active high
	input dpf_pkg::lane_wr_t lane_wr,
	input logic rd,
	output dpf_pkg::lane_sta_t sta,
	output dpf_pkg::rd_rsp_t rsp
);
	import dpf_pkg::*;

	localparam int DEPTH = 2**`DPF_ADR_WIDTH;

	sym_t mem [DEPTH];
	lane_adr_t wp; // Write pointer
	lane_adr_t rp; // Read pointer
	lane_wrds_t wrds;
	sym_t rd_dat;
	logic de;
	logic clr;
	logic ep;
	logic fl;

	assign clr = (lane_wr.op == LANE_CLEAR);

	// Write pointer, wraps at depth
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			wp <= '0;
		else
		begin
			if (clr)
				wp <= '0;
			else if (lane_wr.op == LANE_WRITE)
				wp <= wp + 1'b1;
		end
	end

	// Read pointer
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			rp <= '0;
		else
		begin
			if (clr)
				rp <= '0;
			else if (rd)
				rp <= rp + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge RST_IN)
	begin
		if (lane_wr.op == LANE_WRITE)
			mem[wp] <= lane_wr.dat;
	end

	// Read data register
	always_ff @(posedge RST_IN)
	begin
		if (rd)
			rd_dat <= mem[rp];
	end

	// Data enable, one cycle after the read strobe
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			de <= 1'b0;
		else
			de <= rd && !clr;
	end

	// Used words
	// Registered for timing, the flag below lags by one edge
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			wrds <= '0;
		else
			wrds <= {1'b0, lane_adr_t'(wp - rp)}; // Modulo depth
	end

	assign ep = (wp == rp); // Combinational from pointers
	assign fl = (wrds > lane_wrds_t'(DEPTH - 2));

	assign sta = '{wrds: wrds, ep: ep, fl: fl};
	assign rsp = '{de: de, dat: rd_dat};

endmodule

// File: logic/lane_collector.sv
// Reads the lanes back in the same round-robin order as the distributor
// A read on an empty lane or during clear is dropped
// Read data comes back from the lane that was read one cycle earlier

`timescale 1ns/100ps

`include "dpf_params.svh"

module lane_collector
(
	input logic RST_IN, // Clock
	input logic CLK_IN, // Reset
	input logic clr,
	input logic rd,
	input dpf_pkg::lane_sta_t [`DPF_LANES-1:0] lane_sta,
	input dpf_pkg::rd_rsp_t [`DPF_LANES-1:0] lane_rsp,
	output logic [`DPF_LANES-1:0] lane_rd, // One-hot
	output dpf_pkg::rd_rsp_t rd_rsp,
	output dpf_pkg::bank_wrds_t wrds,
	output logic ep
);
	import dpf_pkg::*;

	lane_sel_t rsel; // Next lane to read
	lane_sel_t lsel; // Lane read last
	logic rd_ok;
	bank_wrds_t wrds_sum;

	// Bank is empty when the next lane is
	assign ep = lane_sta[rsel].ep;
	assign rd_ok = rd && !clr && !ep;

	// Read lane selector
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			rsel <= '0;
		else
		begin
			if (clr)
				rsel <= '0;
			else if (rd_ok)
			begin
				if (rsel == lane_sel_t'(`DPF_LANES - 1))
					rsel <= '0;
				else
					rsel <= rsel + 1'b1;
			end
		end
	end

	// Remember which lane owns the data coming back
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			lsel <= '0;
		else if (rd_ok)
			lsel <= rsel;
	end

	// Lane read strobes
	always_comb
	begin
		for (int i = 0; i < `DPF_LANES; i++)
			lane_rd[i] = rd_ok && (rsel == lane_sel_t'(i));
	end

	// Only the lane read last can have de high
	assign rd_rsp = lane_rsp[lsel];

	// Total of the lane counts
	always_comb
	begin
		wrds_sum = '0;
		for (int i = 0; i < `DPF_LANES; i++)
			wrds_sum = wrds_sum + bank_wrds_t'(lane_sta[i].wrds);
	end

	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			wrds <= '0;
		else
			wrds <= wrds_sum; // Second register stage after the lanes
	end

endmodule

// File: logic/dp_fifo_bank.sv
// Striped symbol FIFO, DPF_LANES lane FIFOs used in round-robin order
// Symbols leave in arrival order, read data follows a read by one cycle
// No back-pressure, writes when full and reads when empty are lost

`timescale 1ns/100ps

`include "dpf_params.svh"

module dp_fifo_bank
(
	input logic RST_IN, // Clock
	input logic CLK_IN, // Reset, async active high
	input logic clr,
	input logic wr,
	input dpf_pkg::sym_t wr_dat,
	input logic rd,
	output dpf_pkg::rd_rsp_t rd_rsp,
	output dpf_pkg::bank_wrds_t wrds,
	output logic ep,
	output logic fl
);
	import dpf_pkg::*;

	wire lane_wr_t [`DPF_LANES-1:0] lane_wr;
	wire lane_sta_t [`DPF_LANES-1:0] lane_sta;
	wire rd_rsp_t [`DPF_LANES-1:0] lane_rsp;
	wire [`DPF_LANES-1:0] lane_rd;

	lane_distributor lane_distributor_inst
	(
		.RST_IN (RST_IN),
		.CLK_IN (CLK_IN),
		.clr (clr),
		.wr (wr),
		.wr_dat (wr_dat),
		.lane_sta (lane_sta),
		.lane_wr (lane_wr),
		.fl (fl)
	);

	// Lane bank
	for (genvar g = 0; g < `DPF_LANES; g++)
	begin : gen_lane
		lane_fifo lane_fifo_inst
		(
			.RST_IN (RST_IN),
			.CLK_IN (CLK_IN),
			.lane_wr (lane_wr[g]),
			.rd (lane_rd[g]),
			.sta (lane_sta[g]),
			.rsp (lane_rsp[g])
		);
	end

	lane_collector lane_collector_inst
	(
		.RST_IN (RST_IN),
		.CLK_IN (CLK_IN),
		.clr (clr),
		.rd (rd),
		.lane_sta (lane_sta),
		.lane_rsp (lane_rsp),
		.lane_rd (lane_rd),
		.rd_rsp (rd_rsp),
		.wrds (wrds),
		.ep (ep)
	);

endmodule

// File: bench/dp_fifo_bank_props.sv
// Lane FIFO assertions, bound into every lane of the bank
// Sampled on the clock edge and off while reset is high

`timescale 1ns/100ps

module dp_fifo_bank_props
(
	input logic RST_IN, // Clock
	input logic CLK_IN, // Reset
	input dpf_pkg::lane_wr_t lane_wr,
	input logic rd,
	input dpf_pkg::lane_sta_t sta,
	input dpf_pkg::rd_rsp_t rsp
);
	import dpf_pkg::*;

	ep_fl_excl: assert property (@(posedge RST_IN) disable iff (CLK_IN)
		!(sta.ep && sta.fl))
		else $error("Lane empty and full are high together");

	// Fixed one-cycle read latency
	de_after_rd: assert property (@(posedge RST_IN) disable iff (CLK_IN)
		rsp.de |-> $past(rd))
		else $error("Lane data enable without a read strobe one cycle earlier");

	// Used words stay below depth, one write too many wraps the pointers to empty
	no_overflow: assert property (@(posedge RST_IN) disable iff (CLK_IN)
		((lane_wr.op == LANE_WRITE) && !rd) |=> !sta.ep)
		else $error("Lane took a write beyond its depth and now reads as empty");

endmodule

bind lane_fifo dp_fifo_bank_props dp_fifo_bank_props_inst
(
	.RST_IN (RST_IN),
	.CLK_IN (CLK_IN),
	.lane_wr (lane_wr),
	.rd (rd),
	.sta (sta),
	.rsp (rsp)
);

// File: bench/dp_fifo_bank_checker.sv
// Queue model of the bank, fed by the strobes the DUT accepts at its ports
// Checks de timing, read data and ep on every clock edge

`timescale 1ns/100ps

module dp_fifo_bank_checker
(
	input logic RST_IN, // Clock
	input logic CLK_IN, // Reset
	input logic clr,
	input logic wr,
	input dpf_pkg::sym_t wr_dat,
	input logic rd,
	input dpf_pkg::rd_rsp_t rd_rsp,
	input dpf_pkg::bank_wrds_t wrds,
	input logic ep,
	input logic fl,
	output int err_cnt
);
	import dpf_pkg::*;

	sym_t model [$];
	sym_t dat_exp; // Symbol due with the next de
	logic de_exp;
	int mon_err = 0; // Found by the edge monitor
	int stat_err = 0; // Found by status checks
	int prev_err = 0;
	int tests_run = 0;
	int tests_failed = 0;

	assign err_cnt = mon_err + stat_err;

	always @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			model.delete();
			de_exp = 1'b0;
		end
		else
		begin
			if (rd_rsp.de !== de_exp)
			begin
				$display("[ERROR] rd_rsp.de expected 0x%h got 0x%h", de_exp, rd_rsp.de);
				mon_err++;
			end
			else if (de_exp && rd_rsp.dat !== dat_exp)
			begin
				$display("[ERROR] rd_rsp.dat expected 0x%h got 0x%h", dat_exp, rd_rsp.dat);
				mon_err++;
			end
			if (ep !== (model.size() == 0))
			begin
				$display("[ERROR] ep expected 0x%h got 0x%h", model.size() == 0, ep);
				mon_err++;
			end
			// Strobes taken at this edge
			de_exp = 1'b0;
			if (clr)
				model.delete();
			else
			begin
				if (rd && !ep)
				begin
					if (model.size() == 0)
					begin
						$display("Read accepted while the model holds no symbols");
						mon_err++;
					end
					else
					begin
						dat_exp = model.pop_front();
						de_exp = 1'b1;
					end
				end
				if (wr && !fl)
					model.push_back(wr_dat);
			end
		end
	end

	task automatic flag_status_mismatch(input string sig, input int exp, input int got);
		$display("[ERROR] %s expected 0x%0h got 0x%0h", sig, exp, got);
		stat_err++;
	endtask

	task automatic check_status(input int exp_wrds, input bit exp_ep, input bit exp_fl,
		input bit use_tab);
		bank_wrds_t mdl_wrds;
		mdl_wrds = bank_wrds_t'(model.size());
		if (wrds !== mdl_wrds)
			flag_status_mismatch("wrds", mdl_wrds, wrds);
		if (use_tab)
		begin
			if (wrds !== bank_wrds_t'(exp_wrds))
				flag_status_mismatch("wrds", exp_wrds, wrds);
			if (ep !== exp_ep)
				flag_status_mismatch("ep", exp_ep, ep);
			if (fl !== exp_fl)
				flag_status_mismatch("fl", exp_fl, fl);
		end
	endtask

	task automatic close_test(input string name);
		int errs;
		errs = mon_err + stat_err - prev_err;
		prev_err = mon_err + stat_err;
		tests_run++;
		if (errs == 0)
			$display("[PASS] %s", name);
		else
		begin
			tests_failed++;
			$display("[FAIL] %s, %0d errors", name, errs);
		end
	endtask

	task automatic print_counts();
		$display("Tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, mon_err + stat_err);
	endtask

endmodule

// File: bench/dp_fifo_bank_tb.sv
// Top testbench for the striped symbol FIFO bank
// Each table row is followed by three settle cycles and a status check
// Drain waits for ep with a cycle limit, a timeout ends the run

`timescale 1ns/100ps

module dp_fifo_bank_tb;
	import dpf_pkg::*;

	typedef enum {ACT_IDLE, ACT_WRITE, ACT_READ, ACT_CLEAR, ACT_MIX, ACT_DRAIN} act_e;

	typedef struct
	{
		act_e act;
		int n; // Strobes, cycles or read limit
		int exp_wrds;
		bit exp_ep;
		bit exp_fl;
		bit use_tab; // Table values apply
		string name;
	} row_t;

	localparam int ROWS = 13;

	logic RST_IN; // Clock
	logic CLK_IN; // Reset
	logic clr;
	logic wr;
	logic rd;
	sym_t wr_dat;
	rd_rsp_t rd_rsp;
	bank_wrds_t wrds;
	logic ep;
	logic fl;
	int err_cnt;
	row_t tab [ROWS];
	int next_sym;
	bit timed_out;

	always #50 RST_IN = ~RST_IN;

	dp_fifo_bank dp_fifo_bank_inst
	(
		.RST_IN (RST_IN),
		.CLK_IN (CLK_IN),
		.clr (clr),
		.wr (wr),
		.wr_dat (wr_dat),
		.rd (rd),
		.rd_rsp (rd_rsp),
		.wrds (wrds),
		.ep (ep),
		.fl (fl)
	);

	dp_fifo_bank_checker checker_inst
	(
		.RST_IN (RST_IN),
		.CLK_IN (CLK_IN),
		.clr (clr),
		.wr (wr),
		.wr_dat (wr_dat),
		.rd (rd),
		.rd_rsp (rd_rsp),
		.wrds (wrds),
		.ep (ep),
		.fl (fl),
		.err_cnt (err_cnt)
	);

	// 28 = four lanes of seven symbols
	task automatic load_table();
		tab[0] = '{ACT_IDLE, 2, 0, 1'b1, 1'b0, 1'b1, "reset state"};
		tab[1] = '{ACT_READ, 1, 0, 1'b1, 1'b0, 1'b1, "read on empty bank"};
		tab[2] = '{ACT_WRITE, 12, 12, 1'b0, 1'b0, 1'b1, "write 12"};
		tab[3] = '{ACT_READ, 12, 0, 1'b1, 1'b0, 1'b1, "read 12 in order"};
		tab[4] = '{ACT_WRITE, 32, 28, 1'b0, 1'b1, 1'b1, "write 32 until full"};
		tab[5] = '{ACT_READ, 28, 0, 1'b1, 1'b0, 1'b1, "read back 28"};
		tab[6] = '{ACT_WRITE, 20, 20, 1'b0, 1'b0, 1'b1, "burst of 20 writes"};
		tab[7] = '{ACT_READ, 7, 13, 1'b0, 1'b0, 1'b1, "partial read of 7"};
		tab[8] = '{ACT_CLEAR, 1, 0, 1'b1, 1'b0, 1'b1, "clear when part full"};
		tab[9] = '{ACT_WRITE, 1, 1, 1'b0, 1'b0, 1'b1, "write after clear"};
		tab[10] = '{ACT_READ, 1, 0, 1'b1, 1'b0, 1'b1, "read after clear"};
		tab[11] = '{ACT_MIX, 200, 0, 1'b0, 1'b0, 1'b0, "random mix"};
		tab[12] = '{ACT_DRAIN, 64, 0, 1'b1, 1'b0, 1'b1, "drain after mix"};
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge RST_IN);
			clr = 1'b0;
			wr = 1'b0;
			rd = 1'b0;
		end
	endtask

	task automatic drive_writes(input int n);
		repeat (n)
		begin
			@(negedge RST_IN);
			wr = 1'b1;
			rd = 1'b0;
			wr_dat = sym_t'(next_sym); // Distinct symbols
			next_sym++;
		end
	endtask

	task automatic drive_reads(input int n);
		repeat (n)
		begin
			@(negedge RST_IN);
			wr = 1'b0;
			rd = 1'b1;
		end
	endtask

	task automatic random_mix(input int n);
		repeat (n)
		begin
			@(negedge RST_IN);
			wr = ($urandom % 2) == 1;
			rd = ($urandom % 2) == 1;
			wr_dat = sym_t'($urandom);
		end
	endtask

	task automatic drain_bank(input int limit);
		int cnt;
		cnt = 0;
		@(negedge RST_IN);
		while (!ep && cnt < limit)
		begin
			wr = 1'b0;
			rd = 1'b1;
			cnt++;
			@(negedge RST_IN);
		end
		rd = 1'b0;
		if (!ep)
		begin
			timed_out = 1'b1;
			$display("Timeout, bank still not empty after %0d read cycles", limit);
		end
	endtask

	task automatic run_row(input row_t r);
		case (r.act)
			ACT_WRITE: drive_writes(r.n);
			ACT_READ: drive_reads(r.n);
			ACT_CLEAR:
			begin
				@(negedge RST_IN);
				clr = 1'b1;
				wr = 1'b0;
				rd = 1'b0;
			end
			ACT_MIX: random_mix(r.n);
			ACT_DRAIN: drain_bank(r.n);
			default: idle_cycles(r.n);
		endcase
		idle_cycles(3); // Bank wrds settles two edges after the last strobe
		checker_inst.check_status(r.exp_wrds, r.exp_ep, r.exp_fl, r.use_tab);
		checker_inst.close_test(r.name);
	endtask

	task automatic finish_run();
		idle_cycles(1);
		checker_inst.print_counts();
		if (timed_out || err_cnt != 0)
			$display("Test FAILED");
		else
			$display("Test OK");
		$finish;
	endtask

	initial
	begin
		void'($urandom(73));
		RST_IN = 1'b0;
		CLK_IN = 1'b1;
		clr = 1'b0;
		wr = 1'b0;
		rd = 1'b0;
		wr_dat = '0;
		next_sym = 1;
		timed_out = 1'b0;
		load_table();
		repeat (5) @(negedge RST_IN);
		CLK_IN = 1'b0;
		for (int i = 0; i < ROWS; i++)
		begin
			if (!timed_out)
				run_row(tab[i]);
		end
		finish_run();
	end

endmodule

// File: tb.f
+incdir+common
common/dpf_pkg.sv
logic/lane_distributor.sv
lane_fifo/lane_fifo.sv
logic/lane_collector.sv
logic/dp_fifo_bank.sv
bench/dp_fifo_bank_props.sv
bench/dp_fifo_bank_checker.sv
bench/dp_fifo_bank_tb.sv
